//--- hw/pinmux_config.svh
`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// ---------------------------------------------------------------------------
// Pad bank and function counts
// ---------------------------------------------------------------------------
`define PINMUX_PADS      16
`define PINMUX_PWM_CH    2

// Microsecond divider and millisecond ratio
`define PINMUX_DIV_W     10
`define PINMUX_MS_DIV    1000

// PWM high and low counts, in ms ticks
`define PINMUX_PWM_W     16

// Fixed pads of the alternate functions
`define PINMUX_PAD_RXD   0
`define PINMUX_PAD_TXD   1
`define PINMUX_PAD_PWM0  4
`define PINMUX_PAD_PWM1  5

`endif

//--- hw/pinmux_reg_pkg.sv
`include "pinmux_config.svh"

package pinmux_reg_pkg;

  // APB byte addresses of the register map
  typedef enum logic [7:0] {
    GPIO_OUT    = 8'h00,
    GPIO_DIR    = 8'h04,  // 1 means output
    GPIO_IN     = 8'h08,  // Read only
    INT_POS_SEL = 8'h0C,
    INT_NEG_SEL = 8'h10,
    INT_STATUS  = 8'h14,  // Write 1 to clear
    FUNC_SEL    = 8'h18,
    PULSE_1US   = 8'h1C,
    PWM0        = 8'h20,
    PWM1        = 8'h24
  } reg_addr_e;

  // One APB bus word
  typedef logic [31:0] apb_data_t;

  // PWM register layout, low count in the upper half
  typedef struct packed {
    logic [`PINMUX_PWM_W-1:0] low;
    logic [`PINMUX_PWM_W-1:0] high;
  } pwm_reg_t;

endpackage

//--- hw/pinmux_pad_pkg.sv
`include "pinmux_config.svh"

package pinmux_pad_pkg;

  // One bit per pad, also one bit per GPIO
  typedef logic [`PINMUX_PADS-1:0] pad_vec_t;

  // Count of ms ticks for a PWM phase
  typedef logic [`PINMUX_PWM_W-1:0] pwm_time_t;

  // One bit per PWM channel
  typedef logic [`PINMUX_PWM_CH-1:0] pwm_vec_t;

  // PWM phase, the wave level while enabled
  typedef enum logic {
    PWM_LOW  = 1'b0,
    PWM_HIGH = 1'b1
  } pwm_phase_e;

endpackage

//--- hw/pinmux_apb_regs.sv
`include "pinmux_config.svh"

module pinmux_apb_regs (
  input  logic                                          mclk_i,
  input  logic                                          arst_n_i,
  // APB slave
  input  logic                                          psel_i,
  input  logic                                          penable_i,
  input  logic                                          pwrite_i,
  input  logic [$bits(pinmux_reg_pkg::reg_addr_e)-1:0]  paddr_i,
  input  pinmux_reg_pkg::apb_data_t                     pwdata_i,
  output pinmux_reg_pkg::apb_data_t                     prdata_o,
  output logic                                          pready_o,
  // From the edge detector
  input  pinmux_pad_pkg::pad_vec_t                      gpio_in_i,
  input  pinmux_pad_pkg::pad_vec_t                      gpio_rise_i,
  input  pinmux_pad_pkg::pad_vec_t                      gpio_fall_i,
  // Configuration to the datapaths
  output pinmux_pad_pkg::pad_vec_t                      gpio_out_o,
  output pinmux_pad_pkg::pad_vec_t                      gpio_dir_o,
  output pinmux_pad_pkg::pwm_vec_t                      pwm_en_o,
  output pinmux_pad_pkg::pwm_time_t                     pwm_high_o [`PINMUX_PWM_CH],
  output pinmux_pad_pkg::pwm_time_t                     pwm_low_o  [`PINMUX_PWM_CH],
  output logic                                          uart_en_o,
  output logic [`PINMUX_DIV_W-1:0]                      cfg_1us_o,
  output logic                                          irq_o
);

  localparam int ADDR_W = $bits(pinmux_reg_pkg::reg_addr_e);

  pinmux_pad_pkg::pad_vec_t  gpio_out_q;
  pinmux_pad_pkg::pad_vec_t  gpio_dir_q;
  pinmux_pad_pkg::pad_vec_t  pos_sel_q;
  pinmux_pad_pkg::pad_vec_t  neg_sel_q;
  pinmux_pad_pkg::pad_vec_t  status_q;
  pinmux_pad_pkg::pad_vec_t  status_set;
  logic [`PINMUX_PWM_CH:0]   func_q;
  logic [`PINMUX_DIV_W-1:0]  cfg_1us_q;
  pinmux_reg_pkg::pwm_reg_t  pwm_q [`PINMUX_PWM_CH];
  pinmux_reg_pkg::apb_data_t rd_data;
  logic                      wr_en;
  logic                      rd_en;

  // PWM channel registers sit one word apart from PWM0
  function automatic logic [ADDR_W-1:0] pwm_addr(input int ch);
    return ADDR_W'(pinmux_reg_pkg::PWM0) + ADDR_W'(4 * ch);
  endfunction

  // ---------------------------------------------------------------------------
  // APB handshake, no wait states
  // ---------------------------------------------------------------------------
  assign pready_o = psel_i & penable_i;
  assign wr_en    = pready_o & pwrite_i;
  assign rd_en    = pready_o & ~pwrite_i;

  // Configuration registers
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
      gpio_dir_q <= '0;
      pos_sel_q  <= '0;
      neg_sel_q  <= '0;
      func_q     <= '0;
      cfg_1us_q  <= '0;
      for (int i = 0; i < `PINMUX_PWM_CH; i++) begin
        pwm_q[i] <= '0;
      end
    end else if (wr_en) begin
      case (paddr_i)
        pinmux_reg_pkg::GPIO_OUT:    gpio_out_q <= pwdata_i[`PINMUX_PADS-1:0];
        pinmux_reg_pkg::GPIO_DIR:    gpio_dir_q <= pwdata_i[`PINMUX_PADS-1:0];
        pinmux_reg_pkg::INT_POS_SEL: pos_sel_q  <= pwdata_i[`PINMUX_PADS-1:0];
        pinmux_reg_pkg::INT_NEG_SEL: neg_sel_q  <= pwdata_i[`PINMUX_PADS-1:0];
        pinmux_reg_pkg::FUNC_SEL:    func_q     <= pwdata_i[`PINMUX_PWM_CH:0];
        pinmux_reg_pkg::PULSE_1US:   cfg_1us_q  <= pwdata_i[`PINMUX_DIV_W-1:0];
        default: ;
      endcase
      for (int i = 0; i < `PINMUX_PWM_CH; i++) begin
        if (paddr_i == pwm_addr(i)) begin
          pwm_q[i] <= pwdata_i;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Interrupt status
  // ---------------------------------------------------------------------------
  // Selected edges only
  assign status_set = (gpio_rise_i & pos_sel_q) | (gpio_fall_i & neg_sel_q);

  // Sticky bits, a new event beats a clear in the same cycle
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_q <= '0;
    end else if (wr_en && paddr_i == pinmux_reg_pkg::INT_STATUS) begin
      status_q <= (status_q & ~pwdata_i[`PINMUX_PADS-1:0]) | status_set;
    end else begin
      status_q <= status_q | status_set;
    end
  end

  assign irq_o = |status_q;

  // Read mux, unmapped words read zero
  always_comb begin
    rd_data = '0;
    case (paddr_i)
      pinmux_reg_pkg::GPIO_OUT:    rd_data[`PINMUX_PADS-1:0]  = gpio_out_q;
      pinmux_reg_pkg::GPIO_DIR:    rd_data[`PINMUX_PADS-1:0]  = gpio_dir_q;
      pinmux_reg_pkg::GPIO_IN:     rd_data[`PINMUX_PADS-1:0]  = gpio_in_i;
      pinmux_reg_pkg::INT_POS_SEL: rd_data[`PINMUX_PADS-1:0]  = pos_sel_q;
      pinmux_reg_pkg::INT_NEG_SEL: rd_data[`PINMUX_PADS-1:0]  = neg_sel_q;
      pinmux_reg_pkg::INT_STATUS:  rd_data[`PINMUX_PADS-1:0]  = status_q;
      pinmux_reg_pkg::FUNC_SEL:    rd_data[`PINMUX_PWM_CH:0]  = func_q;
      pinmux_reg_pkg::PULSE_1US:   rd_data[`PINMUX_DIV_W-1:0] = cfg_1us_q;
      default: ;
    endcase
    for (int i = 0; i < `PINMUX_PWM_CH; i++) begin
      if (paddr_i == pwm_addr(i)) begin
        rd_data = pwm_q[i];
      end
    end
  end

  assign prdata_o = rd_en ? rd_data : '0;

  // ---------------------------------------------------------------------------
  // Field outputs
  // ---------------------------------------------------------------------------
  assign gpio_out_o = gpio_out_q;
  assign gpio_dir_o = gpio_dir_q;
  assign cfg_1us_o  = cfg_1us_q;
  // PWM enables low, UART enable just above them
  assign pwm_en_o   = func_q[`PINMUX_PWM_CH-1:0];
  assign uart_en_o  = func_q[`PINMUX_PWM_CH];

  always_comb begin
    for (int i = 0; i < `PINMUX_PWM_CH; i++) begin
      pwm_high_o[i] = pwm_q[i].high;
      pwm_low_o[i]  = pwm_q[i].low;
    end
  end

endmodule

//--- hw/pinmux_timebase.sv
`include "pinmux_config.svh"

module pinmux_timebase (
  input  logic                     mclk_i,
  input  logic                     arst_n_i,
  input  logic [`PINMUX_DIV_W-1:0] cfg_1us_i,
  output logic                     tick_1us_o,
  output logic                     tick_1ms_o
);

  localparam int MS_W = $clog2(`PINMUX_MS_DIV);

  logic [`PINMUX_DIV_W-1:0] div_cnt_q;
  logic [MS_W-1:0]          ms_cnt_q;
  logic                     div_wrap;
  logic                     ms_wrap;

  // Wrap on the max count, or above it after a smaller write
  assign div_wrap = (div_cnt_q >= cfg_1us_i);
  assign ms_wrap  = (ms_cnt_q == MS_W'(`PINMUX_MS_DIV - 1));

  // Microsecond divider
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_cnt_q  <= '0;
      tick_1us_o <= 1'b0;
    end else begin
      div_cnt_q  <= div_wrap ? '0 : div_cnt_q + 1'b1;
      tick_1us_o <= div_wrap;
    end
  end

  // Count of microsecond ticks
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ms_cnt_q   <= '0;
      tick_1ms_o <= 1'b0;
    end else begin
      tick_1ms_o <= tick_1us_o & ms_wrap;
      if (tick_1us_o) begin
        ms_cnt_q <= ms_wrap ? '0 : ms_cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- hw/pinmux_pwm.sv
`include "pinmux_config.svh"

module pinmux_pwm (
  input  logic                      mclk_i,
  input  logic                      arst_n_i,
  input  logic                      tick_ms_i,
  input  logic                      enable_i,
  input  pinmux_pad_pkg::pwm_time_t high_i,
  input  pinmux_pad_pkg::pwm_time_t low_i,
  output logic                      wave_o
);

  pinmux_pad_pkg::pwm_phase_e phase_q;
  pinmux_pad_pkg::pwm_time_t  cnt_q;
  pinmux_pad_pkg::pwm_time_t  limit;
  logic                       last_tick;

  // Length of the current phase
  assign limit = (phase_q == pinmux_pad_pkg::PWM_HIGH) ? high_i : low_i;

  // Zero count behaves as one tick
  assign last_tick = (limit == '0) || (cnt_q == limit - 1'b1);

  // ---------------------------------------------------------------------------
  // Phase and tick counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= pinmux_pad_pkg::PWM_HIGH;
      cnt_q   <= '0;
    end else if (!enable_i) begin
      // Armed to start in the high phase
      phase_q <= pinmux_pad_pkg::PWM_HIGH;
      cnt_q   <= '0;
    end else if (tick_ms_i) begin
      if (last_tick) begin
        phase_q <= (phase_q == pinmux_pad_pkg::PWM_HIGH) ?
                   pinmux_pad_pkg::PWM_LOW : pinmux_pad_pkg::PWM_HIGH;
        cnt_q   <= '0;
      end else begin
        cnt_q   <= cnt_q + 1'b1;
      end
    end
  end

  // Low whenever the channel is off
  assign wave_o = enable_i & (phase_q == pinmux_pad_pkg::PWM_HIGH);

endmodule

//--- hw/pinmux_gpio_edge.sv
`include "pinmux_config.svh"

module pinmux_gpio_edge (
  input  logic                     mclk_i,
  input  logic                     arst_n_i,
  input  pinmux_pad_pkg::pad_vec_t pad_gpio_i,
  output pinmux_pad_pkg::pad_vec_t gpio_in_o,
  output pinmux_pad_pkg::pad_vec_t rise_o,
  output pinmux_pad_pkg::pad_vec_t fall_o
);

  pinmux_pad_pkg::pad_vec_t sample_q;
  pinmux_pad_pkg::pad_vec_t prev_q;

  // ---------------------------------------------------------------------------
  // Pad sampling
  // ---------------------------------------------------------------------------
  // Current and previous sample of every pad
  always_ff @(posedge mclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_q <= '0;
      prev_q   <= '0;
    end else begin
      sample_q <= pad_gpio_i;
      prev_q   <= sample_q;
    end
  end

  // Readback value for GPIO_IN
  assign gpio_in_o = sample_q;

  // Edge events, one cycle wide
  assign rise_o = sample_q & ~prev_q;
  assign fall_o = ~sample_q & prev_q;

endmodule

//--- hw/pinmux_pad_mux.sv
`include "pinmux_config.svh"

module pinmux_pad_mux (
  input  pinmux_pad_pkg::pad_vec_t pad_in_i,
  input  pinmux_pad_pkg::pad_vec_t gpio_out_i,
  input  pinmux_pad_pkg::pad_vec_t gpio_dir_i,
  input  pinmux_pad_pkg::pwm_vec_t pwm_wave_i,
  input  pinmux_pad_pkg::pwm_vec_t pwm_en_i,
  input  logic                     uart_en_i,
  input  logic                     uart_txd_i,
  output pinmux_pad_pkg::pad_vec_t pad_out_o,
  output pinmux_pad_pkg::pad_vec_t pad_oen_o,
  output pinmux_pad_pkg::pad_vec_t pad_gpio_o,
  output logic                     uart_rxd_o
);

  // Pad of each PWM channel
  localparam int unsigned PWM_PAD [`PINMUX_PWM_CH] = '{
    `PINMUX_PAD_PWM0,
    `PINMUX_PAD_PWM1
  };

  // ---------------------------------------------------------------------------
  // Output and output-enable, alternates override GPIO
  // ---------------------------------------------------------------------------
  always_comb begin
    // GPIO level, output only where the direction bit is set
    pad_out_o = gpio_out_i & gpio_dir_i;
    pad_oen_o = ~gpio_dir_i;

    // PWM waveforms on their fixed pads
    for (int i = 0; i < `PINMUX_PWM_CH; i++) begin
      if (pwm_en_i[i]) begin
        pad_out_o[PWM_PAD[i]] = pwm_wave_i[i];
        pad_oen_o[PWM_PAD[i]] = 1'b0;
      end
    end

    // UART transmit drives, receive forced to input
    if (uart_en_i) begin
      pad_out_o[`PINMUX_PAD_TXD] = uart_txd_i;
      pad_oen_o[`PINMUX_PAD_TXD] = 1'b0;
      pad_out_o[`PINMUX_PAD_RXD] = 1'b0;
      pad_oen_o[`PINMUX_PAD_RXD] = 1'b1;
    end
  end

  // ---------------------------------------------------------------------------
  // Input routing
  // ---------------------------------------------------------------------------
  // GPIO sees every pad
  assign pad_gpio_o = pad_in_i;

  // Receive line held low while the UART is off
  assign uart_rxd_o = uart_en_i & pad_in_i[`PINMUX_PAD_RXD];

endmodule

//--- hw/pinmux_top.sv
`include "pinmux_config.svh"

module pinmux_top (
  input  logic                                         mclk_i,
  input  logic                                         arst_n_i,
  // APB slave
  input  logic                                         psel_i,
  input  logic                                         penable_i,
  input  logic                                         pwrite_i,
  input  logic [$bits(pinmux_reg_pkg::reg_addr_e)-1:0] paddr_i,
  input  pinmux_reg_pkg::apb_data_t                    pwdata_i,
  output pinmux_reg_pkg::apb_data_t                    prdata_o,
  output logic                                         pready_o,
  // Pad bank
  input  pinmux_pad_pkg::pad_vec_t                     pad_in_i,
  output pinmux_pad_pkg::pad_vec_t                     pad_out_o,
  output pinmux_pad_pkg::pad_vec_t                     pad_oen_o,
  // UART and status
  input  logic                                         uart_txd_i,
  output logic                                         uart_rxd_o,
  output logic                                         irq_o,
  output logic                                         pulse_1ms_o
);

  pinmux_pad_pkg::pad_vec_t  gpio_out;
  pinmux_pad_pkg::pad_vec_t  gpio_dir;
  pinmux_pad_pkg::pad_vec_t  gpio_in;
  pinmux_pad_pkg::pad_vec_t  gpio_rise;
  pinmux_pad_pkg::pad_vec_t  gpio_fall;
  pinmux_pad_pkg::pad_vec_t  pad_gpio;
  pinmux_pad_pkg::pwm_vec_t  pwm_en;
  pinmux_pad_pkg::pwm_vec_t  pwm_wave;
  pinmux_pad_pkg::pwm_time_t pwm_high [`PINMUX_PWM_CH];
  pinmux_pad_pkg::pwm_time_t pwm_low  [`PINMUX_PWM_CH];
  logic                      uart_en;
  logic [`PINMUX_DIV_W-1:0]  cfg_1us;

  // ---------------------------------------------------------------------------
  // Control
  // ---------------------------------------------------------------------------
  pinmux_apb_regs u_regs (
    .mclk_i      (mclk_i),
    .arst_n_i    (arst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .gpio_in_i   (gpio_in),
    .gpio_rise_i (gpio_rise),
    .gpio_fall_i (gpio_fall),
    .gpio_out_o  (gpio_out),
    .gpio_dir_o  (gpio_dir),
    .pwm_en_o    (pwm_en),
    .pwm_high_o  (pwm_high),
    .pwm_low_o   (pwm_low),
    .uart_en_o   (uart_en),
    .cfg_1us_o   (cfg_1us),
    .irq_o       (irq_o)
  );

  // Millisecond tick also leaves the tile
  pinmux_timebase u_timebase (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .cfg_1us_i  (cfg_1us),
    .tick_1us_o (),
    .tick_1ms_o (pulse_1ms_o)
  );

  // ---------------------------------------------------------------------------
  // Datapaths
  // ---------------------------------------------------------------------------
  pinmux_gpio_edge u_gpio_edge (
    .mclk_i     (mclk_i),
    .arst_n_i   (arst_n_i),
    .pad_gpio_i (pad_gpio),
    .gpio_in_o  (gpio_in),
    .rise_o     (gpio_rise),
    .fall_o     (gpio_fall)
  );

  for (genvar g = 0; g < `PINMUX_PWM_CH; g++) begin : g_pwm
    pinmux_pwm u_pwm (
      .mclk_i    (mclk_i),
      .arst_n_i  (arst_n_i),
      .tick_ms_i (pulse_1ms_o),
      .enable_i  (pwm_en[g]),
      .high_i    (pwm_high[g]),
      .low_i     (pwm_low[g]),
      .wave_o    (pwm_wave[g])
    );
  end

  pinmux_pad_mux u_pad_mux (
    .pad_in_i   (pad_in_i),
    .gpio_out_i (gpio_out),
    .gpio_dir_i (gpio_dir),
    .pwm_wave_i (pwm_wave),
    .pwm_en_i   (pwm_en),
    .uart_en_i  (uart_en),
    .uart_txd_i (uart_txd_i),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o),
    .pad_gpio_o (pad_gpio),
    .uart_rxd_o (uart_rxd_o)
  );

endmodule

//--- bench/tb_pinmux_model.svh
`ifndef TB_PINMUX_MODEL_SVH
`define TB_PINMUX_MODEL_SVH

// ---------------------------------------------------------------------------
// Shadow register file
// ---------------------------------------------------------------------------
logic [`PINMUX_PADS-1:0]  sh_gpio_out;
logic [`PINMUX_PADS-1:0]  sh_gpio_dir;
logic [`PINMUX_PADS-1:0]  sh_pos_sel;
logic [`PINMUX_PADS-1:0]  sh_neg_sel;
logic [`PINMUX_PADS-1:0]  sh_status;
logic [`PINMUX_PWM_CH:0]  sh_func;
logic [`PINMUX_DIV_W-1:0] sh_cfg_1us;
logic [31:0]              sh_pwm [`PINMUX_PWM_CH];
// Pad level the DUT has settled on
logic [`PINMUX_PADS-1:0]  sh_pads;

// Values after reset
task automatic clear_shadow();
  sh_gpio_out = '0;
  sh_gpio_dir = '0;
  sh_pos_sel  = '0;
  sh_neg_sel  = '0;
  sh_status   = '0;
  sh_func     = '0;
  sh_cfg_1us  = '0;
  sh_pads     = '0;
  for (int i = 0; i < `PINMUX_PWM_CH; i++) begin
    sh_pwm[i] = '0;
  end
endtask

// Effect of one APB write, unmapped words ignored
task automatic update_shadow(input logic [7:0] addr, input logic [31:0] data);
  case (addr)
    pinmux_reg_pkg::GPIO_OUT:    sh_gpio_out = data[`PINMUX_PADS-1:0];
    pinmux_reg_pkg::GPIO_DIR:    sh_gpio_dir = data[`PINMUX_PADS-1:0];
    pinmux_reg_pkg::INT_POS_SEL: sh_pos_sel  = data[`PINMUX_PADS-1:0];
    pinmux_reg_pkg::INT_NEG_SEL: sh_neg_sel  = data[`PINMUX_PADS-1:0];
    pinmux_reg_pkg::INT_STATUS:  sh_status   = sh_status & ~data[`PINMUX_PADS-1:0];
    pinmux_reg_pkg::FUNC_SEL:    sh_func     = data[`PINMUX_PWM_CH:0];
    pinmux_reg_pkg::PULSE_1US:   sh_cfg_1us  = data[`PINMUX_DIV_W-1:0];
    pinmux_reg_pkg::PWM0:        sh_pwm[0]   = data;
    pinmux_reg_pkg::PWM1:        sh_pwm[1]   = data;
    default: ;
  endcase
endtask

// Expected read data of one address
function automatic logic [31:0] expected_read(input logic [7:0] addr);
  logic [31:0] r;
  r = '0;
  case (addr)
    pinmux_reg_pkg::GPIO_OUT:    r[`PINMUX_PADS-1:0]  = sh_gpio_out;
    pinmux_reg_pkg::GPIO_DIR:    r[`PINMUX_PADS-1:0]  = sh_gpio_dir;
    pinmux_reg_pkg::GPIO_IN:     r[`PINMUX_PADS-1:0]  = sh_pads;
    pinmux_reg_pkg::INT_POS_SEL: r[`PINMUX_PADS-1:0]  = sh_pos_sel;
    pinmux_reg_pkg::INT_NEG_SEL: r[`PINMUX_PADS-1:0]  = sh_neg_sel;
    pinmux_reg_pkg::INT_STATUS:  r[`PINMUX_PADS-1:0]  = sh_status;
    pinmux_reg_pkg::FUNC_SEL:    r[`PINMUX_PWM_CH:0]  = sh_func;
    pinmux_reg_pkg::PULSE_1US:   r[`PINMUX_DIV_W-1:0] = sh_cfg_1us;
    pinmux_reg_pkg::PWM0:        r = sh_pwm[0];
    pinmux_reg_pkg::PWM1:        r = sh_pwm[1];
    default:                     r = '0;
  endcase
  return r;
endfunction

// New pad level, selected edges become sticky status
task automatic note_pad_edges(input logic [`PINMUX_PADS-1:0] new_pads);
  sh_status = sh_status | ((new_pads & ~sh_pads) & sh_pos_sel)
                        | ((~new_pads & sh_pads) & sh_neg_sel);
  sh_pads   = new_pads;
endtask

// Pad priority: PWM, then UART, then GPIO output, else input
task automatic predict_pads(input  logic                      txd,
                            input  logic [`PINMUX_PWM_CH-1:0] wave,
                            output logic [`PINMUX_PADS-1:0]   pad_out,
                            output logic [`PINMUX_PADS-1:0]   pad_oen,
                            output logic                      rxd);
  logic uart_on;
  uart_on = sh_func[`PINMUX_PWM_CH];
  for (int p = 0; p < `PINMUX_PADS; p++) begin
    if (sh_func[0] && p == `PINMUX_PAD_PWM0) begin
      pad_out[p] = wave[0];
      pad_oen[p] = 1'b0;
    end else if (sh_func[1] && p == `PINMUX_PAD_PWM1) begin
      pad_out[p] = wave[1];
      pad_oen[p] = 1'b0;
    end else if (uart_on && p == `PINMUX_PAD_TXD) begin
      pad_out[p] = txd;
      pad_oen[p] = 1'b0;
    end else if (!uart_on && sh_gpio_dir[p]) begin
      pad_out[p] = sh_gpio_out[p];
      pad_oen[p] = 1'b0;
    end else if (sh_gpio_dir[p] && p != `PINMUX_PAD_RXD) begin
      pad_out[p] = sh_gpio_out[p];
      pad_oen[p] = 1'b0;
    end else begin
      pad_out[p] = 1'b0;
      pad_oen[p] = 1'b1;
    end
  end
  rxd = uart_on & sh_pads[`PINMUX_PAD_RXD];
endtask

`endif

//--- bench/tb_pinmux.sv
`include "pinmux_config.svh"

module tb_pinmux;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int PIN_W = $clog2(`PINMUX_PADS);

  // Registers with plain read and write
  localparam logic [7:0] RW_ADDR [8] = '{
    pinmux_reg_pkg::GPIO_OUT, pinmux_reg_pkg::GPIO_DIR,
    pinmux_reg_pkg::INT_POS_SEL, pinmux_reg_pkg::INT_NEG_SEL,
    pinmux_reg_pkg::FUNC_SEL, pinmux_reg_pkg::PULSE_1US,
    pinmux_reg_pkg::PWM0, pinmux_reg_pkg::PWM1
  };
  localparam logic [7:0] BAD_ADDR [4] = '{8'h28, 8'h2C, 8'h02, 8'hFC};

  logic                      mclk;
  logic                      arst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [7:0]                paddr;
  pinmux_reg_pkg::apb_data_t pwdata;
  pinmux_reg_pkg::apb_data_t prdata;
  logic                      pready;
  pinmux_pad_pkg::pad_vec_t  pad_in;
  pinmux_pad_pkg::pad_vec_t  pad_out;
  pinmux_pad_pkg::pad_vec_t  pad_oen;
  logic                      uart_txd;
  logic                      uart_rxd;
  logic                      irq;
  logic                      pulse_1ms;

  int                        errors;
  logic [31:0]               rdata;
  logic [2:0]                rw_idx;
  logic [1:0]                bad_idx;
  pinmux_pad_pkg::pad_vec_t  exp_out;
  pinmux_pad_pkg::pad_vec_t  exp_oen;
  logic                      exp_rxd;
  logic [PIN_W-1:0]          pwm_pin;
  int                        ticks;
  int                        ch;
  int unsigned               hi_len;
  int unsigned               lo_len;

  `include "tb_pinmux_model.svh"

  pinmux_top u_dut (
    .mclk_i      (mclk),
    .arst_n_i    (arst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out),
    .pad_oen_o   (pad_oen),
    .uart_txd_i  (uart_txd),
    .uart_rxd_o  (uart_rxd),
    .irq_o       (irq),
    .pulse_1ms_o (pulse_1ms)
  );

  initial begin
    mclk = 1'b0;
    forever #5 mclk = ~mclk;
  end

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Setup phase, then access phase until pready
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge mclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge mclk);
    #1;
    penable = 1'b1;
    @(negedge mclk);
    while (!pready) begin
      if (waited == 8) begin
        abort_run("timeout waiting for pready_o during an APB write");
      end
      waited++;
      @(negedge mclk);
    end
    @(posedge mclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    update_shadow(addr, data);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge mclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge mclk);
    #1;
    penable = 1'b1;
    @(negedge mclk);
    while (!pready) begin
      if (waited == 8) begin
        abort_run("timeout waiting for pready_o during an APB read");
      end
      waited++;
      @(negedge mclk);
    end
    // Mid-cycle sample of the read data
    data = prdata;
    @(posedge mclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic drive_pads(input pinmux_pad_pkg::pad_vec_t value);
    @(posedge mclk);
    #1;
    pad_in = value;
    note_pad_edges(value);
  endtask

  task automatic wait_irq();
    int waited;
    waited = 0;
    @(negedge mclk);
    while (!irq) begin
      if (waited == 8) begin
        abort_run("timeout waiting for irq_o after a selected pad edge");
      end
      waited++;
      @(negedge mclk);
    end
  endtask

  // Ms ticks seen while a PWM pad holds one level
  task automatic count_ticks_while(input logic [PIN_W-1:0] pin, input logic level,
                                   output int count);
    int cycles;
    count  = 0;
    cycles = 0;
    @(negedge mclk);
    while (pad_out[pin] == level) begin
      if (pulse_1ms) begin
        count++;
      end
      if (cycles == TIMEOUT_CYCLES) begin
        abort_run($sformatf("timeout waiting for PWM pad %0d to leave level %0b",
                            pin, level));
      end
      cycles++;
      @(negedge mclk);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    void'($urandom(32'h3652_bbe8));
    errors   = 0;
    arst_n   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    pad_in   = '0;
    uart_txd = 1'b0;
    clear_shadow();
    repeat (3) @(posedge mclk);
    #1;
    arst_n = 1'b1;

    // Reset state
    @(negedge mclk);
    predict_pads(uart_txd, '1, exp_out, exp_oen, exp_rxd);
    check_equal("pad_out_o", 32'(pad_out), 32'(exp_out));
    check_equal("pad_oen_o", 32'(pad_oen), 32'(exp_oen));
    check_equal("irq_o", 32'(irq), 32'h0);
    check_equal("pulse_1ms_o", 32'(pulse_1ms), 32'h0);
    check_equal("pready_o", 32'(pready), 32'h0);

    // Random register traffic
    for (int n = 0; n < 64; n++) begin
      rw_idx = 3'($urandom);
      write_reg(RW_ADDR[rw_idx], $urandom);
      rw_idx = 3'($urandom);
      read_reg(RW_ADDR[rw_idx], rdata);
      check_equal($sformatf("prdata_o@%02h", RW_ADDR[rw_idx]), rdata,
                  expected_read(RW_ADDR[rw_idx]));
    end
    for (int n = 0; n < 8; n++) begin
      bad_idx = 2'($urandom);
      write_reg(BAD_ADDR[bad_idx], $urandom);
      read_reg(BAD_ADDR[bad_idx], rdata);
      check_equal($sformatf("prdata_o@%02h", BAD_ADDR[bad_idx]), rdata, 32'h0);
    end
    // Unmapped writes left the map alone
    for (int i = 0; i < 8; i++) begin
      read_reg(RW_ADDR[i], rdata);
      check_equal($sformatf("prdata_o@%02h", RW_ADDR[i]), rdata, expected_read(RW_ADDR[i]));
    end

    // Pad priority, PWMs held in a long high phase
    write_reg(pinmux_reg_pkg::FUNC_SEL, 32'h0);
    write_reg(pinmux_reg_pkg::PWM0, 32'h0001_FFFF);
    write_reg(pinmux_reg_pkg::PWM1, 32'h0001_FFFF);
    for (int n = 0; n < 32; n++) begin
      write_reg(pinmux_reg_pkg::GPIO_OUT, $urandom);
      write_reg(pinmux_reg_pkg::GPIO_DIR, $urandom);
      write_reg(pinmux_reg_pkg::FUNC_SEL, $urandom_range(7));
      drive_pads(pinmux_pad_pkg::pad_vec_t'($urandom));
      uart_txd = 1'($urandom);
      @(negedge mclk);
      predict_pads(uart_txd, '1, exp_out, exp_oen, exp_rxd);
      check_equal("pad_out_o", 32'(pad_out), 32'(exp_out));
      check_equal("pad_oen_o", 32'(pad_oen), 32'(exp_oen));
      check_equal("uart_rxd_o", 32'(uart_rxd), 32'(exp_rxd));
    end

    // GPIO_IN readback
    for (int n = 0; n < 16; n++) begin
      drive_pads(pinmux_pad_pkg::pad_vec_t'($urandom));
      read_reg(pinmux_reg_pkg::GPIO_IN, rdata);
      check_equal("GPIO_IN", rdata, expected_read(pinmux_reg_pkg::GPIO_IN));
    end

    // Edge interrupts, status cleared by writing it back
    write_reg(pinmux_reg_pkg::INT_POS_SEL, $urandom);
    write_reg(pinmux_reg_pkg::INT_NEG_SEL, $urandom);
    write_reg(pinmux_reg_pkg::INT_STATUS, 32'hFFFF_FFFF);
    for (int n = 0; n < 24; n++) begin
      drive_pads(pinmux_pad_pkg::pad_vec_t'($urandom));
      if (sh_status != '0) begin
        wait_irq();
      end else begin
        repeat (3) @(negedge mclk);
      end
      check_equal("irq_o", 32'(irq), 32'(|sh_status));
      read_reg(pinmux_reg_pkg::INT_STATUS, rdata);
      check_equal("INT_STATUS", rdata, expected_read(pinmux_reg_pkg::INT_STATUS));
      write_reg(pinmux_reg_pkg::INT_STATUS, 32'(sh_status));
      @(negedge mclk);
      check_equal("irq_o", 32'(irq), 32'h0);
      read_reg(pinmux_reg_pkg::INT_STATUS, rdata);
      check_equal("INT_STATUS", rdata, 32'h0);
    end

    // PWM phase lengths in ms ticks, 1 us every 2 clocks
    write_reg(pinmux_reg_pkg::PULSE_1US, 32'h1);
    for (int n = 0; n < 4; n++) begin
      ch      = n % 2;
      hi_len  = $urandom_range(3);
      lo_len  = $urandom_range(3);
      pwm_pin = (ch == 0) ? PIN_W'(`PINMUX_PAD_PWM0) : PIN_W'(`PINMUX_PAD_PWM1);
      write_reg(pinmux_reg_pkg::FUNC_SEL, 32'h0);
      write_reg((ch == 0) ? pinmux_reg_pkg::PWM0 : pinmux_reg_pkg::PWM1,
                {16'(lo_len), 16'(hi_len)});
      write_reg(pinmux_reg_pkg::FUNC_SEL, 32'(1 << ch));
      // Skip ahead to the first rising edge
      count_ticks_while(pwm_pin, 1'b1, ticks);
      count_ticks_while(pwm_pin, 1'b0, ticks);
      count_ticks_while(pwm_pin, 1'b1, ticks);
      check_equal($sformatf("pwm%0d high ticks", ch), ticks, (hi_len == 0) ? 1 : hi_len);
      count_ticks_while(pwm_pin, 1'b0, ticks);
      check_equal($sformatf("pwm%0d low ticks", ch), ticks, (lo_len == 0) ? 1 : lo_len);
    end

    if (errors == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run("checks failed before the end of the run");
    end
  end

endmodule

//--- verilog.f
+incdir+hw
+incdir+bench
hw/pinmux_reg_pkg.sv
hw/pinmux_pad_pkg.sv
hw/pinmux_apb_regs.sv
hw/pinmux_timebase.sv
hw/pinmux_pwm.sv
hw/pinmux_gpio_edge.sv
hw/pinmux_pad_mux.sv
hw/pinmux_top.sv
bench/tb_pinmux.sv

//--- Makefile
TOP := tb_pinmux

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f verilog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f verilog.f --top-module pinmux_top
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
